// File: compile.f
hw/soc_pkg.sv
hw/bus_interconnect.sv
hw/sram_slave.sv
hw/dma_engine.sv
hw/soc_top.sv
tb/tb_soc_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_soc_top
RTL_TOP   ?= soc_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= sim passed
VFLAGS    ?= --timing --assert
SIMFLAGS  ?= --binary -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIMFLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: tb/tb_soc_top.sv
`timescale 1ns/100ps

module tb_soc_top;

    // Sized for about 2000 host operations and 8 copies of up to 64 words
    localparam int TIMEOUT_CYCLES = 200000;
    localparam int MODEL_WORDS    = 2 * soc_pkg::SRAM_WORDS;
    localparam int RANDOM_OPS     = 1000;
    localparam int READBACK_LOOPS = 16;
    localparam int DMA_COPIES     = 8;
    localparam int MAX_COPY_LEN   = 64;
    localparam soc_pkg::addr_t DMA_BASE = 32'h0000_2000;

    logic              clk;
    logic              rst_n;
    soc_pkg::bus_req_t host_req;
    logic              host_req_valid;
    logic              host_req_ready;
    soc_pkg::bus_rsp_t host_rsp;
    logic              host_rsp_valid;
    logic              host_rsp_ready;
    logic              dma_irq;

    // Reference model of both SRAMs and the DMA registers
    soc_pkg::data_t mem_model [MODEL_WORDS];
    soc_pkg::addr_t m_src;
    soc_pkg::addr_t m_dst;
    soc_pkg::len_t  m_len;
    logic           m_irq;

    int ops_issued = 0;
    int rsp_count  = 0;
    int cycles     = 0;

    soc_top uut (
        .clk            (clk),
        .rst_n          (rst_n),
        .host_req       (host_req),
        .host_req_valid (host_req_valid),
        .host_req_ready (host_req_ready),
        .host_rsp       (host_rsp),
        .host_rsp_valid (host_rsp_valid),
        .host_rsp_ready (host_rsp_ready),
        .dma_irq        (dma_irq)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("The run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("sim failed");
            $fatal(1, "timeout");
        end
    end

    // Responses counted at their transfer
    always @(negedge clk) begin
        if (rst_n && host_rsp_valid && host_rsp_ready) begin
            rsp_count <= rsp_count + 1;
        end
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    task automatic check_equal(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            $display("sim failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic soc_pkg::addr_t sram_addr(int idx);
        soc_pkg::addr_t bank;
        soc_pkg::addr_t word;
        bank = idx / soc_pkg::SRAM_WORDS;
        word = idx % soc_pkg::SRAM_WORDS;
        return (bank << soc_pkg::SLAVE_SEL_LSB) | (word << 2);
    endfunction

    function automatic int model_index(soc_pkg::addr_t addr);
        return int'(addr[soc_pkg::SLAVE_SEL_LSB]) * soc_pkg::SRAM_WORDS + int'(addr[9:2]);
    endfunction

    function automatic soc_pkg::data_t merge_bytes(soc_pkg::data_t old_word,
                                                   soc_pkg::data_t new_word,
                                                   soc_pkg::strb_t strb);
        soc_pkg::data_t res;
        for (int b = 0; b < 4; b++) begin
            res[8*b +: 8] = strb[b] ? new_word[8*b +: 8] : old_word[8*b +: 8];
        end
        return res;
    endfunction

    // Register value as seen while the DMA is idle
    function automatic soc_pkg::data_t expected_reg(logic [3:0] off);
        case (off)
            soc_pkg::DMA_REG_SRC: return m_src;
            soc_pkg::DMA_REG_DST: return m_dst;
            soc_pkg::DMA_REG_LEN: return {16'h0, m_len};
            default:              return {30'h0, m_irq, 1'b0};
        endcase
    endfunction

    function automatic int pick_range_start(int len);
        int bank;
        bank = $urandom % 2;
        return bank * soc_pkg::SRAM_WORDS + ($urandom % (soc_pkg::SRAM_WORDS + 1 - len));
    endfunction

    // One host transaction with random stalls on the response ready
    task automatic bus_access(input soc_pkg::addr_t addr, input soc_pkg::data_t wdata,
                              input soc_pkg::strb_t strb, input logic write,
                              output soc_pkg::data_t rdata, output logic err);
        @(posedge clk);
        host_req.addr  <= addr;
        host_req.wdata <= wdata;
        host_req.wstrb <= strb;
        host_req.write <= write;
        host_req_valid <= 1'b1;
        @(negedge clk);
        while (!host_req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        host_req_valid <= 1'b0;
        host_rsp_ready <= ($urandom % 4) != 0;
        @(negedge clk);
        while (!(host_rsp_valid && host_rsp_ready)) begin
            @(posedge clk);
            host_rsp_ready <= ($urandom % 4) != 0;
            @(negedge clk);
        end
        rdata = host_rsp.rdata;
        err   = host_rsp.err;
        ops_issued++;
    endtask

    task automatic write_word(soc_pkg::addr_t addr, soc_pkg::data_t wdata, soc_pkg::strb_t strb);
        int             idx;
        soc_pkg::data_t rdata;
        logic           err;
        idx = model_index(addr);
        bus_access(addr, wdata, strb, 1'b1, rdata, err);
        check_equal("host_rsp.err", err, 1'b0);
        check_equal("host_rsp.rdata", rdata, mem_model[idx]);
        mem_model[idx] = merge_bytes(mem_model[idx], wdata, strb);
    endtask

    task automatic read_word(soc_pkg::addr_t addr);
        soc_pkg::data_t rdata;
        logic           err;
        bus_access(addr, '0, '0, 1'b0, rdata, err);
        check_equal("host_rsp.err", err, 1'b0);
        check_equal("host_rsp.rdata", rdata, mem_model[model_index(addr)]);
    endtask

    task automatic unmapped_access;
        soc_pkg::addr_t addr;
        soc_pkg::data_t rdata;
        logic           err;
        addr = $urandom;
        if ($urandom % 2) begin
            addr[13:12] = 2'b11;
        end else begin
            addr[14 + ($urandom % 18)] = 1'b1;
        end
        bus_access(addr, $urandom, 4'($urandom), 1'($urandom), rdata, err);
        check_equal("host_rsp.err", err, 1'b1);
        check_equal("host_rsp.rdata", rdata, '0);
        // The SRAM word with the same low address bits stays untouched
        if (!addr[13]) begin
            read_word(sram_addr(model_index(addr)));
        end
    endtask

    task automatic reg_access(input logic [3:0] off, input soc_pkg::data_t wdata,
                              input logic write, output soc_pkg::data_t rdata);
        logic err;
        bus_access(DMA_BASE | off, wdata, 4'hF, write, rdata, err);
        check_equal("host_rsp.err", err, 1'b0);
    endtask

    // Register write while the DMA is idle
    task automatic reg_write(logic [3:0] off, soc_pkg::data_t wdata);
        soc_pkg::data_t old;
        reg_access(off, wdata, 1'b1, old);
        check_equal("dma reg old value", old, expected_reg(off));
        case (off)
            soc_pkg::DMA_REG_SRC: m_src = wdata;
            soc_pkg::DMA_REG_DST: m_dst = wdata;
            soc_pkg::DMA_REG_LEN: m_len = wdata[15:0];
            default:              m_irq = 1'b0;
        endcase
    endtask

    task automatic reg_check(logic [3:0] off, string name);
        soc_pkg::data_t rdata;
        reg_access(off, '0, 1'b0, rdata);
        check_equal(name, rdata, expected_reg(off));
    endtask

    // ------------------------------------------------------------------------
    // Test phases
    // ------------------------------------------------------------------------
    task automatic fill_memory;
        soc_pkg::addr_t addr;
        soc_pkg::data_t data;
        soc_pkg::data_t rdata;
        logic           err;
        for (int i = 0; i < MODEL_WORDS; i++) begin
            addr = sram_addr(i);
            data = {addr[15:0], ~addr[15:0]} ^ $urandom;
            bus_access(addr, data, 4'hF, 1'b1, rdata, err);
            check_equal("host_rsp.err", err, 1'b0);
            mem_model[i] = data;
        end
    endtask

    task automatic register_readback;
        for (int n = 0; n < READBACK_LOOPS; n++) begin
            reg_write(soc_pkg::DMA_REG_SRC, $urandom);
            reg_write(soc_pkg::DMA_REG_DST, $urandom);
            reg_write(soc_pkg::DMA_REG_LEN, $urandom);
            reg_check(soc_pkg::DMA_REG_SRC, "dma src");
            reg_check(soc_pkg::DMA_REG_DST, "dma dst");
            reg_check(soc_pkg::DMA_REG_LEN, "dma len");
            reg_check(soc_pkg::DMA_REG_CTRL, "dma ctrl");
        end
        // Start with LEN zero leaves the DMA idle
        reg_write(soc_pkg::DMA_REG_LEN, '0);
        reg_write(soc_pkg::DMA_REG_CTRL, 32'h1);
        reg_check(soc_pkg::DMA_REG_CTRL, "dma ctrl");
        check_equal("dma_irq", dma_irq, 1'b0);
    endtask

    task automatic dma_copy;
        int             len;
        int             src_idx;
        int             dst_idx;
        int             other;
        soc_pkg::data_t ctrl;
        soc_pkg::data_t old;
        len = 1 + ($urandom % MAX_COPY_LEN);
        do begin
            src_idx = pick_range_start(len);
            dst_idx = pick_range_start(len);
        end while ((src_idx < dst_idx + len) && (dst_idx < src_idx + len));

        reg_write(soc_pkg::DMA_REG_SRC, sram_addr(src_idx));
        reg_write(soc_pkg::DMA_REG_DST, sram_addr(dst_idx));
        reg_write(soc_pkg::DMA_REG_LEN, len);
        reg_access(soc_pkg::DMA_REG_CTRL, 32'h1, 1'b1, old);
        check_equal("dma ctrl old value", old, expected_reg(soc_pkg::DMA_REG_CTRL));
        m_irq = 1'b0;

        // Host traffic outside the destination while the copy runs
        ctrl = '0;
        while (!ctrl[soc_pkg::CTRL_IRQ_BIT]) begin
            do begin
                other = $urandom % MODEL_WORDS;
            end while ((other >= dst_idx) && (other < dst_idx + len));
            read_word(sram_addr(other));
            reg_access(soc_pkg::DMA_REG_CTRL, '0, 1'b0, ctrl);
            check_equal("dma ctrl upper bits", ctrl >> 2, '0);
            check_equal("dma ctrl busy", ctrl[soc_pkg::CTRL_START_BIT],
                        !ctrl[soc_pkg::CTRL_IRQ_BIT]);
        end
        check_equal("dma_irq", dma_irq, 1'b1);

        for (int i = 0; i < len; i++) begin
            mem_model[dst_idx + i] = mem_model[src_idx + i];
        end
        m_src = m_src + 32'(4 * len);
        m_dst = m_dst + 32'(4 * len);
        m_len = '0;
        m_irq = 1'b1;
        reg_check(soc_pkg::DMA_REG_SRC, "dma src");
        reg_check(soc_pkg::DMA_REG_DST, "dma dst");
        reg_check(soc_pkg::DMA_REG_LEN, "dma len");

        reg_write(soc_pkg::DMA_REG_CTRL, '0);
        check_equal("dma_irq", dma_irq, 1'b0);
        for (int i = 0; i < len; i++) begin
            read_word(sram_addr(dst_idx + i));
        end
    endtask

    initial begin
        void'($urandom(32'h7eb3));
        rst_n          = 1'b0;
        host_req       = '0;
        host_req_valid = 1'b0;
        host_rsp_ready = 1'b0;
        m_src          = '0;
        m_dst          = '0;
        m_len          = '0;
        m_irq          = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_equal("host_rsp_valid", host_rsp_valid, 1'b0);
        check_equal("dma_irq", dma_irq, 1'b0);

        fill_memory();
        for (int n = 0; n < RANDOM_OPS; n++) begin
            case ($urandom % 10)
                0, 1, 2, 3, 4: write_word(sram_addr($urandom % MODEL_WORDS), $urandom,
                                          4'($urandom));
                9:             unmapped_access();
                default:       read_word(sram_addr($urandom % MODEL_WORDS));
            endcase
        end
        register_readback();
        for (int n = 0; n < DMA_COPIES; n++) begin
            dma_copy();
        end

        repeat (2) @(posedge clk);
        check_equal("response count", rsp_count, ops_issued);
        $display("sim passed");
        $finish;
    end

endmodule

// File: hw/soc_top.sv
`timescale 1ns/100ps

module soc_top (
    input  logic              clk,
    input  logic              rst_n,

    input  soc_pkg::bus_req_t host_req,
    input  logic              host_req_valid,
    output logic              host_req_ready,
    output soc_pkg::bus_rsp_t host_rsp,
    output logic              host_rsp_valid,
    input  logic              host_rsp_ready,

    output logic              dma_irq
);

    // ------------------------------------------------------------------------
    // Master 0 is the host and master 1 the DMA
    // ------------------------------------------------------------------------
    soc_pkg::bus_req_t m_req [2];
    logic [1:0]        m_req_valid;
    logic [1:0]        m_req_ready;
    soc_pkg::bus_rsp_t m_rsp [2];
    logic [1:0]        m_rsp_valid;
    logic [1:0]        m_rsp_ready;

    soc_pkg::bus_req_t s_req [3];
    logic [2:0]        s_req_valid;
    logic [2:0]        s_req_ready;
    soc_pkg::bus_rsp_t s_rsp [3];
    logic [2:0]        s_rsp_valid;
    logic [2:0]        s_rsp_ready;

    assign m_req[0]       = host_req;
    assign m_req_valid[0] = host_req_valid;
    assign host_req_ready = m_req_ready[0];
    assign host_rsp       = m_rsp[0];
    assign host_rsp_valid = m_rsp_valid[0];
    assign m_rsp_ready[0] = host_rsp_ready;

    bus_interconnect u_interconnect (
        .clk         (clk),
        .rst_n       (rst_n),
        .m_req       (m_req),
        .m_req_valid (m_req_valid),
        .m_req_ready (m_req_ready),
        .m_rsp       (m_rsp),
        .m_rsp_valid (m_rsp_valid),
        .m_rsp_ready (m_rsp_ready),
        .s_req       (s_req),
        .s_req_valid (s_req_valid),
        .s_req_ready (s_req_ready),
        .s_rsp       (s_rsp),
        .s_rsp_valid (s_rsp_valid),
        .s_rsp_ready (s_rsp_ready)
    );

    sram_slave u_sram0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (s_req[soc_pkg::SLAVE_SRAM0]),
        .req_valid (s_req_valid[soc_pkg::SLAVE_SRAM0]),
        .req_ready (s_req_ready[soc_pkg::SLAVE_SRAM0]),
        .rsp       (s_rsp[soc_pkg::SLAVE_SRAM0]),
        .rsp_valid (s_rsp_valid[soc_pkg::SLAVE_SRAM0]),
        .rsp_ready (s_rsp_ready[soc_pkg::SLAVE_SRAM0])
    );

    sram_slave u_sram1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (s_req[soc_pkg::SLAVE_SRAM1]),
        .req_valid (s_req_valid[soc_pkg::SLAVE_SRAM1]),
        .req_ready (s_req_ready[soc_pkg::SLAVE_SRAM1]),
        .rsp       (s_rsp[soc_pkg::SLAVE_SRAM1]),
        .rsp_valid (s_rsp_valid[soc_pkg::SLAVE_SRAM1]),
        .rsp_ready (s_rsp_ready[soc_pkg::SLAVE_SRAM1])
    );

    dma_engine u_dma (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_req       (s_req[soc_pkg::SLAVE_DMA]),
        .cfg_req_valid (s_req_valid[soc_pkg::SLAVE_DMA]),
        .cfg_req_ready (s_req_ready[soc_pkg::SLAVE_DMA]),
        .cfg_rsp       (s_rsp[soc_pkg::SLAVE_DMA]),
        .cfg_rsp_valid (s_rsp_valid[soc_pkg::SLAVE_DMA]),
        .cfg_rsp_ready (s_rsp_ready[soc_pkg::SLAVE_DMA]),
        .mst_req       (m_req[1]),
        .mst_req_valid (m_req_valid[1]),
        .mst_req_ready (m_req_ready[1]),
        .mst_rsp       (m_rsp[1]),
        .mst_rsp_valid (m_rsp_valid[1]),
        .mst_rsp_ready (m_rsp_ready[1]),
        .irq           (dma_irq)
    );

endmodule

// File: hw/dma_engine.sv
`timescale 1ns/100ps

module dma_engine (
    input  logic              clk,
    input  logic              rst_n,

    input  soc_pkg::bus_req_t cfg_req,
    input  logic              cfg_req_valid,
    output logic              cfg_req_ready,
    output soc_pkg::bus_rsp_t cfg_rsp,
    output logic              cfg_rsp_valid,
    input  logic              cfg_rsp_ready,

    output soc_pkg::bus_req_t mst_req,
    output logic              mst_req_valid,
    input  logic              mst_req_ready,
    input  soc_pkg::bus_rsp_t mst_rsp,
    input  logic              mst_rsp_valid,
    output logic              mst_rsp_ready,

    output logic              irq
);

    typedef enum logic [2:0] {
        DMA_IDLE,
        DMA_RD_REQ,
        DMA_RD_RSP,
        DMA_WR_REQ,
        DMA_WR_RSP
    } dma_state_t;

    dma_state_t      dma_state;
    soc_pkg::addr_t  src;
    soc_pkg::addr_t  dst;
    soc_pkg::len_t   len;
    logic            busy;
    soc_pkg::data_t  rd_buf;

    logic [3:0]      cfg_off;
    logic            cfg_fire;
    soc_pkg::data_t  cur_word;
    soc_pkg::data_t  wr_word;

    // ------------------------------------------------------------------------
    // Register slave port
    // ------------------------------------------------------------------------
    assign cfg_off       = cfg_req.addr[3:0];
    assign cfg_req_ready = !cfg_rsp_valid;
    assign cfg_fire      = cfg_req_valid && cfg_req_ready;

    always_comb begin
        cur_word = '0;
        case (cfg_off)
            soc_pkg::DMA_REG_SRC: cur_word = src;
            soc_pkg::DMA_REG_DST: cur_word = dst;
            soc_pkg::DMA_REG_LEN: cur_word = {16'b0, len};
            soc_pkg::DMA_REG_CTRL: begin
                cur_word[soc_pkg::CTRL_START_BIT] = busy;
                cur_word[soc_pkg::CTRL_IRQ_BIT]   = irq;
            end
            default: cur_word = '0;
        endcase
    end

    assign wr_word = soc_pkg::merge_strb(cur_word, cfg_req.wdata, cfg_req.wstrb);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg_rsp_valid <= 1'b0;
        end else if (cfg_fire) begin
            cfg_rsp_valid <= 1'b1;
        end else if (cfg_rsp_ready) begin
            cfg_rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_fire) begin
            cfg_rsp.rdata <= cur_word;
            cfg_rsp.err   <= 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    // Registers and copy FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            src       <= '0;
            dst       <= '0;
            len       <= '0;
            busy      <= 1'b0;
            irq       <= 1'b0;
            dma_state <= DMA_IDLE;
        end else begin
            if (cfg_fire && cfg_req.write) begin
                case (cfg_off)
                    soc_pkg::DMA_REG_SRC: begin
                        if (!busy) begin
                            src <= wr_word;
                        end
                    end
                    soc_pkg::DMA_REG_DST: begin
                        if (!busy) begin
                            dst <= wr_word;
                        end
                    end
                    soc_pkg::DMA_REG_LEN: begin
                        if (!busy) begin
                            len <= wr_word[$bits(soc_pkg::len_t)-1:0];
                        end
                    end
                    soc_pkg::DMA_REG_CTRL: begin
                        irq <= 1'b0;
                        if (wr_word[soc_pkg::CTRL_START_BIT] && !busy && (len != '0)) begin
                            busy      <= 1'b1;
                            dma_state <= DMA_RD_REQ;
                        end
                    end
                    default: ;
                endcase
            end

            // Errors on the master port do not stop the copy
            case (dma_state)
                DMA_RD_REQ: begin
                    if (mst_req_ready) begin
                        dma_state <= DMA_RD_RSP;
                    end
                end
                DMA_RD_RSP: begin
                    if (mst_rsp_valid) begin
                        dma_state <= DMA_WR_REQ;
                    end
                end
                DMA_WR_REQ: begin
                    if (mst_req_ready) begin
                        dma_state <= DMA_WR_RSP;
                    end
                end
                DMA_WR_RSP: begin
                    if (mst_rsp_valid) begin
                        src <= src + 32'd4;
                        dst <= dst + 32'd4;
                        len <= len - 16'd1;
                        if (len == 16'd1) begin
                            busy      <= 1'b0;
                            irq       <= 1'b1;
                            dma_state <= DMA_IDLE;
                        end else begin
                            dma_state <= DMA_RD_REQ;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((dma_state == DMA_RD_RSP) && mst_rsp_valid) begin
            rd_buf <= mst_rsp.rdata;
        end
    end

    // Master port payload follows the FSM state
    always_comb begin
        mst_req.addr  = (dma_state == DMA_WR_REQ) ? dst : src;
        mst_req.wdata = (dma_state == DMA_WR_REQ) ? rd_buf : '0;
        mst_req.wstrb = (dma_state == DMA_WR_REQ) ? 4'hF : 4'h0;
        mst_req.write = (dma_state == DMA_WR_REQ);
    end

    assign mst_req_valid = (dma_state == DMA_RD_REQ) || (dma_state == DMA_WR_REQ);
    assign mst_rsp_ready = (dma_state == DMA_RD_RSP) || (dma_state == DMA_WR_RSP);

    a_mst_busy: assert property (@(posedge clk) disable iff (!rst_n)
        mst_req_valid |-> busy);

endmodule

// File: hw/sram_slave.sv
`timescale 1ns/100ps

module sram_slave (
    input  logic              clk,
    input  logic              rst_n,

    input  soc_pkg::bus_req_t req,
    input  logic              req_valid,
    output logic              req_ready,

    output soc_pkg::bus_rsp_t rsp,
    output logic              rsp_valid,
    input  logic              rsp_ready
);

    soc_pkg::data_t     mem [soc_pkg::SRAM_WORDS];
    soc_pkg::word_idx_t idx;
    logic               req_fire;

    // Word index from the low address bits
    assign idx       = req.addr[2 +: $bits(soc_pkg::word_idx_t)];
    assign req_ready = !rsp_valid;
    assign req_fire  = req_valid && req_ready;

    // ------------------------------------------------------------------------
    // Response handshake
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else if (req_fire) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    // Old word goes back on writes too
    always_ff @(posedge clk) begin
        if (req_fire) begin
            rsp.rdata <= mem[idx];
            rsp.err   <= 1'b0;
            if (req.write) begin
                mem[idx] <= soc_pkg::merge_strb(mem[idx], req.wdata, req.wstrb);
            end
        end
    end

    a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (rsp_valid && !rsp_ready) |=> $stable(rsp));

endmodule

// File: hw/bus_interconnect.sv
`timescale 1ns/100ps

module bus_interconnect (
    input  logic              clk,
    input  logic              rst_n,

    input  soc_pkg::bus_req_t m_req [2],
    input  logic [1:0]        m_req_valid,
    output logic [1:0]        m_req_ready,
    output soc_pkg::bus_rsp_t m_rsp [2],
    output logic [1:0]        m_rsp_valid,
    input  logic [1:0]        m_rsp_ready,

    output soc_pkg::bus_req_t s_req [3],
    output logic [2:0]        s_req_valid,
    input  logic [2:0]        s_req_ready,
    input  soc_pkg::bus_rsp_t s_rsp [3],
    input  logic [2:0]        s_rsp_valid,
    output logic [2:0]        s_rsp_ready
);

    soc_pkg::ic_state_t state;
    logic               grant;
    logic               rr_ptr;
    logic [1:0]         sel;
    logic               unmapped;

    logic               pick;
    soc_pkg::addr_t     pick_addr;
    logic [1:0]         pick_sel;
    logic               pick_unmapped;
    soc_pkg::bus_req_t  gnt_req;
    soc_pkg::bus_rsp_t  rsp_mux;
    logic               req_ready_mux;
    logic               rsp_valid_mux;
    logic               req_fire;
    logic               rsp_fire;

    // ------------------------------------------------------------------------
    // Arbitration and decode
    // ------------------------------------------------------------------------
    // Pointer master wins when it asks, otherwise the other one
    assign pick      = m_req_valid[rr_ptr] ? rr_ptr : ~rr_ptr;
    assign pick_addr = m_req[pick].addr;
    assign pick_sel  = pick_addr[soc_pkg::SLAVE_SEL_LSB +: 2];

    // Select 3 or anything above the select field has no slave
    assign pick_unmapped = (pick_addr[31:soc_pkg::SLAVE_SEL_LSB+2] != '0) ||
                           (pick_sel > soc_pkg::SLAVE_DMA);

    assign gnt_req = m_req[grant];

    // ------------------------------------------------------------------------
    // Slave side routing
    // ------------------------------------------------------------------------
    always_comb begin
        req_ready_mux = unmapped;
        rsp_valid_mux = unmapped;
        rsp_mux       = '{rdata: '0, err: 1'b1};
        for (int i = 0; i < 3; i++) begin
            s_req[i]       = gnt_req;
            s_req_valid[i] = (state == soc_pkg::IC_REQ) && !unmapped &&
                             (sel == 2'(i)) && m_req_valid[grant];
            s_rsp_ready[i] = (state == soc_pkg::IC_RSP) && !unmapped &&
                             (sel == 2'(i)) && m_rsp_ready[grant];
            if (!unmapped && (sel == 2'(i))) begin
                req_ready_mux = s_req_ready[i];
                rsp_valid_mux = s_rsp_valid[i];
                rsp_mux       = s_rsp[i];
            end
        end
    end

    // Only the granted master sees ready and valid
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            m_rsp[i]       = rsp_mux;
            m_req_ready[i] = (state == soc_pkg::IC_REQ) && (grant == 1'(i)) && req_ready_mux;
            m_rsp_valid[i] = (state == soc_pkg::IC_RSP) && (grant == 1'(i)) && rsp_valid_mux;
        end
    end

    assign req_fire = (state == soc_pkg::IC_REQ) && m_req_valid[grant] && req_ready_mux;
    assign rsp_fire = (state == soc_pkg::IC_RSP) && rsp_valid_mux && m_rsp_ready[grant];

    // ------------------------------------------------------------------------
    // Transaction FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= soc_pkg::IC_IDLE;
            grant    <= 1'b0;
            rr_ptr   <= 1'b0;
            sel      <= '0;
            unmapped <= 1'b0;
        end else begin
            case (state)
                soc_pkg::IC_IDLE: begin
                    if (|m_req_valid) begin
                        grant    <= pick;
                        sel      <= pick_sel;
                        unmapped <= pick_unmapped;
                        state    <= soc_pkg::IC_REQ;
                    end
                end
                soc_pkg::IC_REQ: begin
                    if (req_fire) begin
                        state <= soc_pkg::IC_RSP;
                    end
                end
                soc_pkg::IC_RSP: begin
                    if (rsp_fire) begin
                        rr_ptr <= ~grant;
                        state  <= soc_pkg::IC_IDLE;
                    end
                end
                default: state <= soc_pkg::IC_IDLE;
            endcase
        end
    end

    a_grant_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (state != soc_pkg::IC_IDLE) |=> $stable(grant));

    a_one_slave: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(s_req_valid));

endmodule

// File: hw/soc_pkg.sv
package soc_pkg;

    // ------------------------------------------------------------------------
    // Vector types
    // ------------------------------------------------------------------------
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [7:0]  word_idx_t;
    typedef logic [15:0] len_t;

    // Single-beat bus payloads
    typedef struct packed {
        addr_t addr;
        data_t wdata;
        strb_t wstrb;
        logic  write;
    } bus_req_t;

    typedef struct packed {
        data_t rdata;
        logic  err;
    } bus_rsp_t;

    // ------------------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------------------
    localparam int SRAM_WORDS    = 256;
    localparam int SLAVE_SEL_LSB = 12;

    localparam logic [1:0] SLAVE_SRAM0 = 2'd0;
    localparam logic [1:0] SLAVE_SRAM1 = 2'd1;
    localparam logic [1:0] SLAVE_DMA   = 2'd2;

    // DMA register byte offsets
    localparam logic [3:0] DMA_REG_SRC  = 4'h0;
    localparam logic [3:0] DMA_REG_DST  = 4'h4;
    localparam logic [3:0] DMA_REG_LEN  = 4'h8;
    localparam logic [3:0] DMA_REG_CTRL = 4'hC;

    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_IRQ_BIT   = 1;

    typedef enum logic [1:0] {
        IC_IDLE,
        IC_REQ,
        IC_RSP
    } ic_state_t;

    // Byte lanes of new_word replace those of old_word where strobed
    function automatic data_t merge_strb(data_t old_word, data_t new_word, strb_t strb);
        data_t res;
        res = old_word;
        for (int b = 0; b < $bits(strb_t); b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return res;
    endfunction

endpackage
